//--- Bender.yml
package:
  name: zx_memsys

sources:
  - include_dirs:
      - source
    files:
      - source/memsys_pkg.sv
      - source/mem_pager.sv
      - source/cpu_mem_port.sv
      - source/video_fetch.sv
      - source/dram_arbiter.sv
      - source/dram_core.sv
      - source/zx_memsys.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - sim/tb_zx_memsys.sv

//--- compile.f
+incdir+source
source/memsys_pkg.sv
source/mem_pager.sv
source/cpu_mem_port.sv
source/video_fetch.sv
source/dram_arbiter.sv
source/dram_core.sv
source/zx_memsys.sv
sim/tb_zx_memsys.sv

//--- sim/memsys_patterns.txt
# columns: P window page | W z80-address byte | R z80-address expected-byte (all hex)
# G word-count (decimal) then the expected video words from offset 0
W 0010 a5
W 4123 3c
W 8456 e1
W c789 7f
R 0010 a5
R 4123 3c
R 8456 e1
R c789 7f
P 1 2
R 4456 e1
P 1 6
P 3 6
W 4200 5a
R c200 5a
W c201 c3
R 4201 c3
P 2 5
W 8001 21
W 8000 10
W 8002 32
W 8003 43
W 8005 65
W 8004 54
W 8006 76
W 8007 87
W 8008 98
W 8009 a9
W 800b cb
W 800a ba
W 800c dc
W 800d ed
W 800e fe
W 800f 0f
G 10 2110 4332 6554 8776 a998 cbba eddc 0ffe 2110 4332
R 8001 21
R 800e fe
W c310 44
R 4310 44
R 8000 10
R 800f 0f
R 8007 87

//--- sim/tb_zx_memsys.sv
////////////////////
// testbench for the memory subsystem
// runs the pattern file against a byte model of the dram
////////////////////

`default_nettype none

`include "memsys_params.svh"

module tb_zx_memsys;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CPU_LIMIT  = 12;
	localparam int WAIT_LIMIT = 40;

	logic                 fclk;
	logic                 rst;
	logic                 cpu_req;
	logic                 cpu_rnw;
	logic [15:0]          cpu_addr;
	logic [7:0]           cpu_wrdata;
	logic [7:0]           cpu_rddata;
	logic                 cpu_done;
	logic                 page_wr;
	logic [1:0]           page_win;
	logic [`PAGE_W-1:0]   page_val;
	logic                 video_go;
	logic                 video_strobe;
	logic [`DATA_W-1:0]   video_data;

	// byte model of the physical memory and of the page registers
	logic [7:0]           model_mem [0:2**`PHYS_AW-1];
	logic [`PAGE_W-1:0]   win_page [4];
	logic [`DATA_W-1:0]   exp_words [$];

	int   errors;
	int   checks;
	logic cpu_busy;
	logic video_on;
	logic video_busy;

	zx_memsys UUT
	(
		.fclk        (fclk        ),
		.rst         (rst         ),
		.cpu_req     (cpu_req     ),
		.cpu_rnw     (cpu_rnw     ),
		.cpu_addr    (cpu_addr    ),
		.cpu_wrdata  (cpu_wrdata  ),
		.cpu_rddata  (cpu_rddata  ),
		.cpu_done    (cpu_done    ),
		.page_wr     (page_wr     ),
		.page_win    (page_win    ),
		.page_val    (page_val    ),
		.video_go    (video_go    ),
		.video_strobe(video_strobe),
		.video_data  (video_data  )
	);

	initial
	begin
		fclk = 1'b0;
		forever #5 fclk = ~fclk;
	end

	// no done or video word may show up unasked
	always @(negedge fclk)
	begin
		if (!rst && !cpu_busy && cpu_done)
		begin
			errors++;
			$display("cpu_done pulsed with no cpu access pending");
		end
		if (!rst && !video_on && video_strobe)
		begin
			errors++;
			$display("video_strobe pulsed while video was off");
		end
	end

	function automatic logic [`PHYS_AW-1:0] phys_of(input logic [15:0] addr);
		return {win_page[addr[15:14]], addr[`WIN_OFS_W-1:0]};
	endfunction

	// word k of the video page, low byte at the even offset
	function automatic logic [`DATA_W-1:0] video_word(input int k);
		logic [`PHYS_AW-1:0] base;
		base = {`PAGE_W'(`VIDEO_PAGE), `WIN_OFS_W'(2 * k)};
		return {model_mem[base + 1], model_mem[base]};
	endfunction

	task automatic finish_run();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	endtask

	task automatic abort_run(input string why);
		errors++;
		$display("%s", why);
		finish_run();
	endtask

	task automatic write_page(input logic [1:0] win, input logic [`PAGE_W-1:0] page);
		@(posedge fclk);
		page_wr  <= 1'b1;
		page_win <= win;
		page_val <= page;
		@(posedge fclk);
		page_wr <= 1'b0;
		win_page[win] = page;
	endtask

	task automatic cpu_access(input logic rnw, input logic [15:0] addr,
		input logic [7:0] wdata, output logic [7:0] rdata);
		int   lat;
		logic seen;
		cpu_busy = 1'b1;
		@(posedge fclk);
		cpu_req    <= 1'b1;
		cpu_rnw    <= rnw;
		cpu_addr   <= addr;
		cpu_wrdata <= wdata;
		lat  = 0;
		seen = 1'b0;
		// lat counts whole cycles from cpu_req up to cpu_done
		while (!seen && lat < WAIT_LIMIT)
		begin
			@(negedge fclk);
			if (cpu_done)
				seen = 1'b1;
			else
				lat++;
		end
		if (!seen)
			abort_run("timeout: cpu access never got cpu_done");
		else
		begin
			rdata = cpu_rddata;
			checks++;
			if (lat > CPU_LIMIT)
			begin
				errors++;
				$display("cpu access at %h took %0d cycles", addr, lat);
			end
			@(posedge fclk);
			cpu_req  <= 1'b0;
			cpu_busy = 1'b0;
		end
	endtask

	////////////////////
	// video run

	task automatic video_run(input int count);
		int   t;
		logic got;
		video_on = 1'b1;
		@(posedge fclk);
		video_go <= 1'b1;
		for (int i = 0; i < count; i++)
		begin
			t   = 0;
			got = 1'b0;
			while (!got && t < WAIT_LIMIT)
			begin
				@(negedge fclk);
				t++;
				if (video_strobe)
					got = 1'b1;
			end
			if (!got)
				abort_run("timeout: video word never arrived");
			else
			begin
				checks++;
				if (video_data !== exp_words[i])
				begin
					errors++;
					$display("ERROR video_data word %0d: expected %h, got %h",
						i, exp_words[i], video_data);
				end
			end
		end
		@(posedge fclk);
		video_go <= 1'b0;
		// words granted before the stop still come back
		repeat (16) @(posedge fclk);
		video_on   = 1'b0;
		video_busy = 1'b0;
	endtask

	task automatic wait_video_idle();
		int t;
		t = 0;
		while (video_busy && t < 400)
		begin
			@(posedge fclk);
			t++;
		end
		if (video_busy)
			abort_run("timeout: video run did not finish");
	endtask

	////////////////////
	// pattern loop

	initial
	begin
		int                fd;
		int                n;
		int                cnt;
		logic [7:0]        op;
		logic [31:0]       f1;
		logic [31:0]       f2;
		logic [7:0]        rd;
		logic [7:0]        exp_b;
		logic [8*120-1:0]  line_buf;

		rst        = 1'b1;
		cpu_req    = 1'b0;
		cpu_rnw    = 1'b1;
		cpu_addr   = '0;
		cpu_wrdata = '0;
		page_wr    = 1'b0;
		page_win   = '0;
		page_val   = '0;
		video_go   = 1'b0;
		errors     = 0;
		checks     = 0;
		cpu_busy   = 1'b0;
		video_on   = 1'b0;
		video_busy = 1'b0;
		void'($urandom(32'h2716fde1));
		for (int i = 0; i < 4; i++)
			win_page[i] = `PAGE_W'(i);

		repeat (10) @(posedge fclk);
		rst <= 1'b0;

		fd = $fopen("sim/memsys_patterns.txt", "r");
		if (fd == 0)
			abort_run("could not open the pattern file");
		else
		begin
			while (!$feof(fd))
			begin
				n = $fscanf(fd, " %c", op);
				if (n == 1)
				begin
					case (op)
						"#":
							n = $fgets(line_buf, fd);
						"P":
						begin
							n = $fscanf(fd, "%h %h", f1, f2);
							write_page(f1[1:0], f2[`PAGE_W-1:0]);
						end
						"W":
						begin
							n = $fscanf(fd, "%h %h", f1, f2);
							cpu_access(1'b0, f1[15:0], f2[7:0], rd);
							model_mem[phys_of(f1[15:0])] = f2[7:0];
						end
						"R":
						begin
							n = $fscanf(fd, "%h %h", f1, f2);
							exp_b = model_mem[phys_of(f1[15:0])];
							if (f2[7:0] !== exp_b)
							begin
								errors++;
								$display("pattern at %h expects %h but the model holds %h",
									f1[15:0], f2[7:0], exp_b);
							end
							cpu_access(1'b1, f1[15:0], 8'h00, rd);
							if (rd !== exp_b)
							begin
								errors++;
								$display("ERROR cpu_rddata at %h: expected %h, got %h",
									f1[15:0], exp_b, rd);
							end
						end
						"G":
						begin
							wait_video_idle();
							n = $fscanf(fd, "%d", cnt);
							exp_words.delete();
							for (int i = 0; i < cnt; i++)
							begin
								n = $fscanf(fd, "%h", f1);
								exp_words.push_back(f1[`DATA_W-1:0]);
								if (f1[`DATA_W-1:0] !== video_word(i % `VIDEO_WORDS))
								begin
									errors++;
									$display("pattern video word %0d does not match the model", i);
								end
							end
							// the stream runs on while the next lines use the cpu port
							video_busy = 1'b1;
							fork
								video_run(cnt);
							join_none
						end
						default:
						begin
							errors++;
							$display("unknown operation in the pattern file");
						end
					endcase
					repeat ($urandom_range(3)) @(posedge fclk);
				end
			end
			$fclose(fd);
			wait_video_idle();
			finish_run();
		end
	end

endmodule

`default_nettype wire

//--- source/cpu_mem_port.sv
////////////////////
// cpu memory port
// one z80 byte access becomes one arbitrated dram word access
////////////////////

`default_nettype none

`include "memsys_params.svh"

module cpu_mem_port
(
	input  wire                        fclk,
	input  wire                        rst,

	input  wire                        cpu_req,
	input  wire                        cpu_rnw,
	input  wire  [`PHYS_AW-1:0]        phys_addr,
	input  wire  [7:0]                 cpu_wrdata,
	output logic [7:0]                 cpu_rddata,
	output logic                       cpu_done,

	output logic                       cpu_dreq,
	output memsys_pkg::cpu_op_e        cpu_drnw,
	output logic [`DRAM_AW-1:0]        cpu_daddr,
	output logic [1:0]                 cpu_dbsel,
	output logic [`DATA_W-1:0]         cpu_dwrdata,

	input  wire                        cpu_next,
	input  wire                        cpu_strobe,
	input  wire  [`DATA_W-1:0]         rddata
);

	import memsys_pkg::*;

	logic req_q;
	logic req_rise;

	assign req_rise = cpu_req && !req_q;

	// request level and done pulse
	always_ff @(posedge fclk)
	begin
		if (rst)
		begin
			req_q    <= 1'b0;
			cpu_dreq <= 1'b0;
			cpu_done <= 1'b0;
		end
		else
		begin
			req_q    <= cpu_req;
			cpu_done <= cpu_strobe;
			if (req_rise)
				cpu_dreq <= 1'b1;
			else if (cpu_next)
				cpu_dreq <= 1'b0;
		end
	end

	// latched access, held until the cycle is done
	always_ff @(posedge fclk)
	begin
		if (req_rise)
		begin
			cpu_daddr   <= phys_addr[`PHYS_AW-1:1];
			// odd byte lives in the upper lane
			cpu_dbsel   <= phys_addr[0] ? 2'b10 : 2'b01;
			cpu_drnw    <= cpu_rnw ? OP_READ : OP_WRITE;
			cpu_dwrdata <= {2{cpu_wrdata}};
		end
		if (cpu_strobe)
			cpu_rddata <= cpu_dbsel[1] ? rddata[15:8] : rddata[7:0];
	end

	a_req_held: assert property (@(posedge fclk) disable iff (rst)
		$rose(cpu_req) |-> cpu_req until_with cpu_done)
	else
		$error("cpu_req dropped before cpu_done");

endmodule

`default_nettype wire

//--- source/dram_arbiter.sv
////////////////////
// dram cycle sequencer and arbiter
// four-phase cycles, owner picked at cycle begin
////////////////////

`default_nettype none

`include "memsys_params.svh"

module dram_arbiter
(
	input  wire                        fclk,
	input  wire                        rst,

	input  wire                        cpu_dreq,
	input  wire  memsys_pkg::cpu_op_e  cpu_drnw,
	input  wire  [`DRAM_AW-1:0]        cpu_daddr,
	input  wire  [1:0]                 cpu_dbsel,
	input  wire  [`DATA_W-1:0]         cpu_dwrdata,

	input  wire                        video_dreq,
	input  wire  [`DRAM_AW-1:0]        video_daddr,

	output logic                       cpu_next,
	output logic                       video_next,
	output logic                       cpu_strobe,
	output logic                       video_strobe_int,

	output logic                       mem_req,
	output memsys_pkg::cpu_op_e        mem_rnw,
	output logic [`DRAM_AW-1:0]        mem_addr,
	output logic [1:0]                 mem_bsel,
	output logic [`DATA_W-1:0]         mem_wrdata,
	output memsys_pkg::dram_phase_e    phase
);

	import memsys_pkg::*;

	dram_owner_e owner;

	////////////////////
	// phase counter

	always_ff @(posedge fclk)
	begin
		if (rst)
			phase <= PH_BEG;
		else if (phase == dram_phase_e'(`CYC_PHASES - 1))
			phase <= PH_BEG;
		else
			phase <= dram_phase_e'(phase + 2'd1);
	end

	////////////////////
	// owner selection

	// video first, but never twice in a row against a waiting cpu
	always_comb
	begin
		cpu_next   = 1'b0;
		video_next = 1'b0;
		if (phase == PH_BEG)
		begin
			if (video_dreq && !(cpu_dreq && owner == OWN_VIDEO))
				video_next = 1'b1;
			else if (cpu_dreq)
				cpu_next = 1'b1;
		end
	end

	always_ff @(posedge fclk)
	begin
		if (rst)
		begin
			owner   <= OWN_NONE;
			mem_req <= 1'b0;
		end
		else if (phase == PH_BEG)
		begin
			mem_req <= cpu_next | video_next;
			if (video_next)
				owner <= OWN_VIDEO;
			else if (cpu_next)
				owner <= OWN_CPU;
			else
				owner <= OWN_NONE;
		end
	end

	// access fields held for the whole cycle
	always_ff @(posedge fclk)
	begin
		if (video_next)
		begin
			mem_rnw  <= OP_READ;
			mem_addr <= video_daddr;
			mem_bsel <= 2'b11;
		end
		else if (cpu_next)
		begin
			mem_rnw    <= cpu_drnw;
			mem_addr   <= cpu_daddr;
			mem_bsel   <= cpu_dbsel;
			mem_wrdata <= cpu_dwrdata;
		end
	end

	// end of cycle goes back to the owner
	assign cpu_strobe       = (phase == PH_END) && (owner == OWN_CPU);
	assign video_strobe_int = (phase == PH_END) && (owner == OWN_VIDEO);

	a_cpu_grant: assert property (@(posedge fclk) disable iff (rst)
		cpu_next |-> !video_next ##(`CYC_PHASES - 1) (cpu_strobe && !video_strobe_int))
	else
		$error("cpu grant not one-hot or not strobed");

	a_video_grant: assert property (@(posedge fclk) disable iff (rst)
		video_next |-> !cpu_next ##(`CYC_PHASES - 1) (video_strobe_int && !cpu_strobe))
	else
		$error("video grant not one-hot or not strobed");

endmodule

`default_nettype wire

//--- source/dram_core.sv
////////////////////
// dram model
// word array with byte lanes, timed by the cycle phase
////////////////////

`default_nettype none

`include "memsys_params.svh"

module dram_core
(
	input  wire                           fclk,

	input  wire                           mem_req,
	input  wire  memsys_pkg::cpu_op_e     mem_rnw,
	input  wire  [`DRAM_AW-1:0]           mem_addr,
	input  wire  [1:0]                    mem_bsel,
	input  wire  [`DATA_W-1:0]            mem_wrdata,
	input  wire  memsys_pkg::dram_phase_e phase,

	output logic [`DATA_W-1:0]            rddata
);

	import memsys_pkg::*;

	logic [`DATA_W-1:0] mem [0:2**`DRAM_AW-1];

	always_ff @(posedge fclk)
	begin
		// write lands in the post-begin phase
		if (mem_req && phase == PH_POST && mem_rnw == OP_WRITE)
		begin
			for (int i = 0; i < `DATA_W / 8; i++)
			begin
				if (mem_bsel[i])
					mem[mem_addr][i*8 +: 8] <= mem_wrdata[i*8 +: 8];
			end
		end
		// read captured before the end, valid at PH_END
		if (mem_req && phase == PH_PRE_END && mem_rnw == OP_READ)
			rddata <= mem[mem_addr];
	end

	a_req_stable: assert property (@(posedge fclk)
		(phase == PH_POST || phase == PH_PRE_END) |=> $stable(mem_req))
	else
		$error("mem_req changed inside a dram cycle");

endmodule

`default_nettype wire

//--- source/mem_pager.sv
////////////////////
// window pager
// four 16k windows, each mapped to a ram page
////////////////////

`default_nettype none

`include "memsys_params.svh"

module mem_pager
(
	input  wire                   fclk,
	input  wire                   rst,

	input  wire                   page_wr,
	input  wire  [1:0]            page_win,
	input  wire  [`PAGE_W-1:0]    page_val,

	input  wire  [15:0]           cpu_addr,
	output logic [`PHYS_AW-1:0]   phys_addr
);

	logic [`PAGE_W-1:0] page_r [4];
	logic [1:0]         win;

	// top two address bits pick the window
	assign win = cpu_addr[15:14];

	always_ff @(posedge fclk)
	begin
		if (rst)
		begin
			// identity map, window i shows page i
			for (int i = 0; i < 4; i++)
			begin
				page_r[i] <= `PAGE_W'(i);
			end
		end
		else if (page_wr)
		begin
			page_r[page_win] <= page_val;
		end
	end

	assign phys_addr = {page_r[win], cpu_addr[`WIN_OFS_W-1:0]};

	////////////////////
	// checks

	a_page_win_known: assert property (@(posedge fclk) disable iff (rst)
		page_wr |-> !$isunknown(page_win))
	else
		$error("page write with unknown window");

endmodule

`default_nettype wire

//--- source/memsys_params.svh
////////////////////
// memory subsystem widths and constants
////////////////////

`ifndef MEMSYS_PARAMS_SVH
`define MEMSYS_PARAMS_SVH

// z80 address split into window page and offset
`define PAGE_W 4
`define WIN_OFS_W 14
`define PHYS_AW (`PAGE_W + `WIN_OFS_W)

// dram word organisation
`define DRAM_AW 17
`define DATA_W 16

// video fetch window
`define VIDEO_PAGE 5
`define VIDEO_WORDS 8

// fclk cycles in one dram cycle
`define CYC_PHASES 4

`endif

//--- source/memsys_pkg.sv
////////////////////
// shared types of the memory subsystem
////////////////////

`default_nettype none

package memsys_pkg;

	// phases of one dram cycle, in order
	typedef enum logic [1:0]
	{
		PH_BEG,
		PH_POST,
		PH_PRE_END,
		PH_END
	} dram_phase_e;

	// who holds the current dram cycle
	typedef enum logic [1:0]
	{
		OWN_NONE,
		OWN_CPU,
		OWN_VIDEO
	} dram_owner_e;

	// access direction
	typedef enum logic
	{
		OP_READ,
		OP_WRITE
	} cpu_op_e;

endpackage

`default_nettype wire

//--- source/video_fetch.sv
////////////////////
// video fetcher
// streams words from the video page in a fixed loop
////////////////////

`default_nettype none

`include "memsys_params.svh"

module video_fetch
(
	input  wire                   fclk,
	input  wire                   rst,

	input  wire                   video_go,
	input  wire                   video_next,
	input  wire                   video_strobe_int,
	input  wire  [`DATA_W-1:0]    rddata,

	output logic                  video_dreq,
	output logic [`DRAM_AW-1:0]   video_daddr,
	output logic                  video_strobe,
	output logic [`DATA_W-1:0]    video_data
);

	localparam int CNT_W = $clog2(`VIDEO_WORDS);

	logic [CNT_W-1:0] word_cnt;

	always_ff @(posedge fclk)
	begin
		if (rst)
		begin
			video_dreq   <= 1'b0;
			video_strobe <= 1'b0;
			word_cnt     <= '0;
		end
		else
		begin
			video_dreq   <= video_go;
			video_strobe <= video_strobe_int;
			// restart from offset 0 whenever video is off
			if (!video_go)
				word_cnt <= '0;
			else if (video_next)
			begin
				if (word_cnt == CNT_W'(`VIDEO_WORDS - 1))
					word_cnt <= '0;
				else
					word_cnt <= word_cnt + 1'b1;
			end
		end
	end

	// word address inside the video page
	assign video_daddr = {`PAGE_W'(`VIDEO_PAGE), (`WIN_OFS_W - 1)'(word_cnt)};

	always_ff @(posedge fclk)
	begin
		if (video_strobe_int)
			video_data <= rddata;
	end

endmodule

`default_nettype wire

//--- source/zx_memsys.sv
////////////////////
// memory subsystem top
// pager, cpu port, video fetcher, arbiter and dram
////////////////////

`default_nettype none

`include "memsys_params.svh"

module zx_memsys
(
	input  wire                   fclk,
	input  wire                   rst,

	// cpu access
	input  wire                   cpu_req,
	input  wire                   cpu_rnw,
	input  wire  [15:0]           cpu_addr,
	input  wire  [7:0]            cpu_wrdata,
	output logic [7:0]            cpu_rddata,
	output logic                  cpu_done,

	// page register write
	input  wire                   page_wr,
	input  wire  [1:0]            page_win,
	input  wire  [`PAGE_W-1:0]    page_val,

	// video stream
	input  wire                   video_go,
	output logic                  video_strobe,
	output logic [`DATA_W-1:0]    video_data
);

	import memsys_pkg::*;

	logic [`PHYS_AW-1:0] phys_addr;

	// cpu side of the arbiter
	logic                cpu_dreq;
	cpu_op_e             cpu_drnw;
	logic [`DRAM_AW-1:0] cpu_daddr;
	logic [1:0]          cpu_dbsel;
	logic [`DATA_W-1:0]  cpu_dwrdata;
	logic                cpu_next;
	logic                cpu_strobe;

	// video side
	logic                video_dreq;
	logic [`DRAM_AW-1:0] video_daddr;
	logic                video_next;
	logic                video_strobe_int;

	// dram side
	logic                mem_req;
	cpu_op_e             mem_rnw;
	logic [`DRAM_AW-1:0] mem_addr;
	logic [1:0]          mem_bsel;
	logic [`DATA_W-1:0]  mem_wrdata;
	dram_phase_e         phase;
	logic [`DATA_W-1:0]  rddata;

	mem_pager u_pager
	(
		.fclk     (fclk     ),
		.rst      (rst      ),
		.page_wr  (page_wr  ),
		.page_win (page_win ),
		.page_val (page_val ),
		.cpu_addr (cpu_addr ),
		.phys_addr(phys_addr)
	);

	cpu_mem_port u_cpu_port
	(
		.fclk       (fclk       ),
		.rst        (rst        ),
		.cpu_req    (cpu_req    ),
		.cpu_rnw    (cpu_rnw    ),
		.phys_addr  (phys_addr  ),
		.cpu_wrdata (cpu_wrdata ),
		.cpu_rddata (cpu_rddata ),
		.cpu_done   (cpu_done   ),
		.cpu_dreq   (cpu_dreq   ),
		.cpu_drnw   (cpu_drnw   ),
		.cpu_daddr  (cpu_daddr  ),
		.cpu_dbsel  (cpu_dbsel  ),
		.cpu_dwrdata(cpu_dwrdata),
		.cpu_next   (cpu_next   ),
		.cpu_strobe (cpu_strobe ),
		.rddata     (rddata     )
	);

	video_fetch u_video
	(
		.fclk            (fclk            ),
		.rst             (rst             ),
		.video_go        (video_go        ),
		.video_next      (video_next      ),
		.video_strobe_int(video_strobe_int),
		.rddata          (rddata          ),
		.video_dreq      (video_dreq      ),
		.video_daddr     (video_daddr     ),
		.video_strobe    (video_strobe    ),
		.video_data      (video_data      )
	);

	dram_arbiter u_arbiter
	(
		.fclk            (fclk            ),
		.rst             (rst             ),
		.cpu_dreq        (cpu_dreq        ),
		.cpu_drnw        (cpu_drnw        ),
		.cpu_daddr       (cpu_daddr       ),
		.cpu_dbsel       (cpu_dbsel       ),
		.cpu_dwrdata     (cpu_dwrdata     ),
		.video_dreq      (video_dreq      ),
		.video_daddr     (video_daddr     ),
		.cpu_next        (cpu_next        ),
		.video_next      (video_next      ),
		.cpu_strobe      (cpu_strobe      ),
		.video_strobe_int(video_strobe_int),
		.mem_req         (mem_req         ),
		.mem_rnw         (mem_rnw         ),
		.mem_addr        (mem_addr        ),
		.mem_bsel        (mem_bsel        ),
		.mem_wrdata      (mem_wrdata      ),
		.phase           (phase           )
	);

	dram_core u_dram
	(
		.fclk      (fclk      ),
		.mem_req   (mem_req   ),
		.mem_rnw   (mem_rnw   ),
		.mem_addr  (mem_addr  ),
		.mem_bsel  (mem_bsel  ),
		.mem_wrdata(mem_wrdata),
		.phase     (phase     ),
		.rddata    (rddata    )
	);

endmodule

`default_nettype wire
